// ==== design/ico_oscillator.sv ====
`timescale 1ns/100ps
`default_nettype none

module ico_oscillator (
	input  logic                          clk10MHz_inv,
	input  logic                          rst_n,
	input  logic [relay_osc_pkg::N_W-1:0] ico_incr,
	output logic                          drive_cycle
);

	import relay_osc_pkg::*;

	// phase accumulator, wraps every 2^ACC_W / ico_incr clocks
	logic [ACC_W-1:0] phase_acc;
	logic [ACC_W-1:0] incr_ext;

	// zero extend the increment to accumulator width
	assign incr_ext = {{(ACC_W - N_W){1'b0}}, ico_incr};

	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			phase_acc <= '0;
		end else begin
			// new increment used on this add
			phase_acc <= phase_acc + incr_ext;
		end
	end

	// msb of the accumulator register is the switching cycle
	// high for the upper half of the phase range
	assign drive_cycle = phase_acc[ACC_W-1];

endmodule

`default_nettype wire

// ==== design/lock_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module lock_monitor (
	input  logic                              clk10MHz_inv,
	input  logic                              rst_n,
	input  logic [relay_osc_pkg::THETA_W-1:0] phase_avg,
	input  logic                              avg_strobe,
	output logic                              locked
);

	import relay_osc_pkg::*;

	// signed error and its magnitude
	int err;
	int err_abs;

	always_comb begin
		err     = int'(phase_avg) - THETA_SET;
		err_abs = (err < 0) ? -err : err;
	end

	// narrow window to enter, wide window to stay
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			locked <= 1'b0;
		end else if (avg_strobe) begin
			if (locked) begin
				// drop out at LOCK_EXIT or above
				locked <= (err_abs < LOCK_EXIT);
			end else begin
				locked <= (err_abs < LOCK_ENTER);
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/loop_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module loop_filter (
	input  logic                              clk10MHz_inv,
	input  logic                              rst_n,
	input  logic [relay_osc_pkg::THETA_W-1:0] phase_count,
	input  logic                              phase_strobe,
	output logic [relay_osc_pkg::THETA_W-1:0] phase_avg,
	output logic                              avg_strobe,
	output logic [relay_osc_pkg::N_W-1:0]     ico_incr
);

	import relay_osc_pkg::*;

	// last AVG_TAPS phase counts, tap 0 newest
	logic [THETA_W-1:0] window [AVG_TAPS];
	// running sum of the window
	logic [SUM_W-1:0] run_sum;
	logic [SUM_W-1:0] sum_next;

	// integrator with PI_FRAC fraction bits
	logic [PI_ACC_W-1:0] pi_acc;
	logic [PI_ACC_W-1:0] pi_next;
	int pi_sum;

	// new count in, oldest tap out
	assign sum_next = run_sum + SUM_W'(phase_count) - SUM_W'(window[AVG_TAPS-1]);

	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < AVG_TAPS; i++) begin
				window[i] <= '0;
			end
			run_sum    <= '0;
			phase_avg  <= '0;
			avg_strobe <= 1'b0;
		end else begin
			avg_strobe <= phase_strobe;
			if (phase_strobe) begin
				window[0] <= phase_count;
				for (int i = 1; i < AVG_TAPS; i++) begin
					window[i] <= window[i-1];
				end
				run_sum   <= sum_next;
				// divide by the tap count
				phase_avg <= sum_next[SUM_W-1:AVG_SHIFT];
			end
		end
	end

	// error is set point minus the fresh average
	always_comb begin
		pi_sum = int'(pi_acc) + THETA_SET - int'(phase_avg);
		if (pi_sum < PI_LO) begin
			pi_next = PI_ACC_W'(PI_LO);
		end else if (pi_sum > PI_HI) begin
			pi_next = PI_ACC_W'(PI_HI);
		end else begin
			pi_next = PI_ACC_W'(pi_sum);
		end
	end

	// one update per averaged sample
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			pi_acc <= PI_ACC_W'(PI_START);
		end else if (avg_strobe) begin
			pi_acc <= pi_next;
		end
	end

	// drop the fraction bits
	assign ico_incr = pi_acc[PI_ACC_W-1:PI_FRAC];

endmodule

`default_nettype wire

// ==== design/phase_detector.sv ====
`timescale 1ns/100ps
`default_nettype none

module phase_detector (
	input  logic                              clk10MHz_inv,
	input  logic                              rst_n,
	input  logic                              drive_cycle,
	input  logic                              current_sign,
	output logic [relay_osc_pkg::THETA_W-1:0] phase_count,
	output logic                              phase_strobe
);

	import relay_osc_pkg::*;

	// two stage sync of cycle and current sign
	logic cyc_d1;
	logic cyc_d2;
	// previous synced cycle, for the edge
	logic cyc_d3;
	logic cur_d1;
	logic cur_d2;

	logic cycle_rise;
	logic agree;
	// clocks of agreement since the last edge
	logic [THETA_W-1:0] agree_cnt;

	assign cycle_rise = cyc_d2 & ~cyc_d3;
	// cycle and current on the same side
	assign agree = (cyc_d2 == cur_d2);

	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			cyc_d1 <= 1'b0;
			cyc_d2 <= 1'b0;
			cyc_d3 <= 1'b0;
			cur_d1 <= 1'b0;
			cur_d2 <= 1'b0;
		end else begin
			cyc_d1 <= drive_cycle;
			cyc_d2 <= cyc_d1;
			cyc_d3 <= cyc_d2;
			cur_d1 <= current_sign;
			cur_d2 <= cur_d1;
		end
	end

	// count P - 2D for a lag of D clocks
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			agree_cnt    <= '0;
			phase_count  <= '0;
			phase_strobe <= 1'b0;
		end else begin
			phase_strobe <= cycle_rise;
			if (cycle_rise) begin
				// publish the finished period, start over
				phase_count <= agree_cnt;
				agree_cnt   <= '0;
			end else if (agree && (agree_cnt != '1)) begin
				// hold at full scale
				agree_cnt <= agree_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/relay_osc_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module relay_osc_core (
	input  logic                              clk10MHz_inv,
	input  logic                              rst_n,
	// sampled sign of the plant current
	input  logic                              current_sign,
	output logic                              drive_cycle,
	output logic [relay_osc_pkg::THETA_W-1:0] phase_count,
	output logic                              phase_strobe,
	output logic [relay_osc_pkg::THETA_W-1:0] phase_avg,
	output logic [relay_osc_pkg::N_W-1:0]     ico_incr,
	output logic                              locked
);

	// average valid, one clock after phase_strobe
	logic avg_strobe;

	// switching cycle from the steered increment
	ico_oscillator u_ico (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.ico_incr     (ico_incr),
		.drive_cycle  (drive_cycle)
	);

	// cycle against current sign, once per period
	phase_detector u_phase (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.drive_cycle  (drive_cycle),
		.current_sign (current_sign),
		.phase_count  (phase_count),
		.phase_strobe (phase_strobe)
	);

	// averaging then integrator
	loop_filter u_filter (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.phase_count  (phase_count),
		.phase_strobe (phase_strobe),
		.phase_avg    (phase_avg),
		.avg_strobe   (avg_strobe),
		.ico_incr     (ico_incr)
	);

	// lock flag, same clock as the increment update
	lock_monitor u_lock (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.phase_avg    (phase_avg),
		.avg_strobe   (avg_strobe),
		.locked       (locked)
	);

endmodule

`default_nettype wire

// ==== design/relay_osc_pkg.sv ====
`default_nettype none

package relay_osc_pkg;

	// phase count and average width
	localparam int THETA_W = 9;
	// ico increment and phase accumulator widths
	localparam int N_W = 15;
	localparam int ACC_W = 16;

	// increment out of reset, roughly 167 clocks per period
	localparam int START_N = 393;
	// increment clamp
	localparam int N_MIN = 300;
	localparam int N_MAX = 500;
	// fractional bits carried by the integrator
	localparam int PI_FRAC = 2;

	// quarter period lag as a phase count
	localparam int THETA_SET = 83;
	// moving average length and divide shift
	localparam int AVG_TAPS = 8;
	localparam int AVG_SHIFT = 3;

	// hysteresis on |avg - set|
	localparam int LOCK_ENTER = 4;
	localparam int LOCK_EXIT = 12;

	// derived sizes and scaled integrator limits
	localparam int SUM_W = THETA_W + AVG_SHIFT;
	localparam int PI_ACC_W = N_W + PI_FRAC;
	localparam int PI_START = START_N * (2 ** PI_FRAC);
	localparam int PI_LO = N_MIN * (2 ** PI_FRAC);
	localparam int PI_HI = N_MAX * (2 ** PI_FRAC);

endpackage

`default_nettype wire

// ==== relay_osc.f ====
+incdir+tb
design/relay_osc_pkg.sv
design/ico_oscillator.sv
design/phase_detector.sv
design/loop_filter.sv
design/lock_monitor.sv
design/relay_osc_core.sv
tb/tb_relay_osc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the relay oscillator testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f relay_osc.f --top-module tb_relay_osc \
	-o sim_relay_osc > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_relay_osc > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== tb/tb_relay_osc_model.svh ====
`ifndef TB_RELAY_OSC_MODEL_SVH
`define TB_RELAY_OSC_MODEL_SVH
`default_nettype none

// agreement clocks over one period for a lag of d clocks
function automatic int agree_count(input int period, input int lag);
	return period - 2 * lag;
endfunction

// mean of the last taps, zeros until the window fills
function automatic int window_average(input int taps [relay_osc_pkg::AVG_TAPS]);
	int sum;
	sum = 0;
	for (int i = 0; i < relay_osc_pkg::AVG_TAPS; i++) begin
		sum += taps[i];
	end
	return sum >> relay_osc_pkg::AVG_SHIFT;
endfunction

// integrator step with error = set point - average
function automatic int pi_step(input int acc, input int avg);
	int next;
	int lo;
	int hi;
	// limits carry the same fraction bits as the integrator
	lo = relay_osc_pkg::N_MIN << relay_osc_pkg::PI_FRAC;
	hi = relay_osc_pkg::N_MAX << relay_osc_pkg::PI_FRAC;
	next = acc + (relay_osc_pkg::THETA_SET - avg);
	if (next < lo) begin
		next = lo;
	end else if (next > hi) begin
		next = hi;
	end
	return next;
endfunction

// increment seen by the oscillator
function automatic int acc_to_incr(input int acc);
	return acc >> relay_osc_pkg::PI_FRAC;
endfunction

// hysteresis, narrow to enter and wide to leave
function automatic bit lock_next(input bit prev, input int avg);
	int err;
	err = avg - relay_osc_pkg::THETA_SET;
	if (err < 0) begin
		err = -err;
	end
	if (prev) begin
		return err < relay_osc_pkg::LOCK_EXIT;
	end
	return err < relay_osc_pkg::LOCK_ENTER;
endfunction

`default_nettype wire
`endif

// ==== tb/tb_relay_osc.sv ====
`timescale 1ns/100ps
`include "tb_relay_osc_model.svh"
`default_nettype none

module tb_relay_osc;

	import relay_osc_pkg::*;

	localparam int STROBE_TIMEOUT = 600;
	localparam int PHASE_STROBES = 48;

	logic clk10MHz_inv;
	logic rst_n;
	logic current_sign;
	logic drive_cycle;
	logic [THETA_W-1:0] phase_count;
	logic phase_strobe;
	logic [THETA_W-1:0] phase_avg;
	logic [N_W-1:0] ico_incr;
	logic locked;

	// plant delay line and its lag in clocks
	logic [95:0] plant_sr;
	int lag;

	// period of drive_cycle seen by the testbench
	int period_cnt;
	int last_period;
	logic cycle_prev;

	// oscillator model and the increment it steps with
	logic [ACC_W-1:0] ico_phase;
	int ico_step;

	// model state
	int win [AVG_TAPS];
	int model_acc;
	bit model_lock;
	int errors;
	int checks;
	int skip;
	bit abort;

	relay_osc_core u_dut (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.current_sign (current_sign),
		.drive_cycle  (drive_cycle),
		.phase_count  (phase_count),
		.phase_strobe (phase_strobe),
		.phase_avg    (phase_avg),
		.ico_incr     (ico_incr),
		.locked       (locked)
	);

	always #50 clk10MHz_inv = ~clk10MHz_inv;

	// plant: current sign follows the cycle by lag clocks
	always @(posedge clk10MHz_inv) begin
		plant_sr     <= {plant_sr[94:0], drive_cycle};
		current_sign <= plant_sr[lag-2];
	end

	// clocks between rising edges of the cycle
	always @(negedge clk10MHz_inv) begin
		period_cnt <= period_cnt + 1;
		cycle_prev <= drive_cycle;
		if (drive_cycle && !cycle_prev) begin
			last_period <= period_cnt + 1;
			period_cnt  <= 0;
		end
	end

	// accumulator adds the held increment every clock
	always @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			ico_phase <= '0;
		end else begin
			ico_phase <= ico_phase + ACC_W'(ico_step);
		end
	end

	// cycle is the accumulator msb
	always @(negedge clk10MHz_inv) begin
		if (rst_n) begin
			check_equal("drive_cycle", int'(ico_phase[ACC_W-1]), int'(drive_cycle));
		end
	end

	task automatic check_equal(input string name, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("FAILED %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_near(input string name, input int exp, input int act);
		checks++;
		// synchronizer alignment allows two counts either way
		assert ((act - exp <= 2) && (exp - act <= 2)) else begin
			errors++;
			$display("FAILED %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic wait_strobe(output bit seen);
		seen = 0;
		for (int i = 0; i < STROBE_TIMEOUT && !seen; i++) begin
			@(negedge clk10MHz_inv);
			seen = phase_strobe;
		end
	endtask

	// one strobe: count, then average, then increment and lock
	task automatic check_strobe(input string name);
		int cnt;
		cnt = int'(phase_count);
		if (skip > 0) begin
			skip--;
		end else begin
			check_near({name, " phase_count"}, agree_count(last_period, lag), cnt);
		end
		for (int i = AVG_TAPS - 1; i > 0; i--) begin
			win[i] = win[i-1];
		end
		win[0] = cnt;
		@(negedge clk10MHz_inv);
		check_equal({name, " phase_avg"}, window_average(win), int'(phase_avg));
		model_acc  = pi_step(model_acc, window_average(win));
		model_lock = lock_next(model_lock, window_average(win));
		@(negedge clk10MHz_inv);
		check_equal({name, " ico_incr"}, acc_to_incr(model_acc), int'(ico_incr));
		check_equal({name, " locked"}, int'(model_lock), int'(locked));
		// oscillator picks up the new increment on its next add
		ico_step = acc_to_incr(model_acc);
	endtask

	// new random lag, then a run of strobes
	task automatic run_phase(input string name, input int lo, input int hi);
		bit seen;
		lag  = $urandom_range(hi, lo);
		// count mixes old and new lag for a while
		skip = 2;
		$display("%s lag %0d", name, lag);
		for (int n = 0; n < PHASE_STROBES && !abort; n++) begin
			wait_strobe(seen);
			if (!seen) begin
				errors++;
				abort = 1;
				$display("no phase_strobe within %0d clocks in %s", STROBE_TIMEOUT, name);
			end else begin
				check_strobe(name);
			end
		end
	endtask

	initial begin
		clk10MHz_inv = 1'b0;
		rst_n        = 1'b0;
		current_sign = 1'b0;
		plant_sr     = '0;
		lag          = 40;
		period_cnt   = 0;
		last_period  = 0;
		cycle_prev   = 1'b0;
		errors       = 0;
		checks       = 0;
		abort        = 0;
		skip         = 0;
		model_lock   = 0;
		model_acc    = START_N << PI_FRAC;
		ico_step     = START_N;
		for (int i = 0; i < AVG_TAPS; i++) begin
			win[i] = 0;
		end
		void'($urandom(32'had784e05));
		repeat (2) @(posedge clk10MHz_inv);
		rst_n <= 1'b1;
		@(negedge clk10MHz_inv);
		// nothing published yet
		check_equal("reset locked", 0, int'(locked));
		check_equal("reset phase_strobe", 0, int'(phase_strobe));
		check_equal("reset ico_incr", START_N, int'(ico_incr));
		check_equal("reset phase_avg", 0, int'(phase_avg));
		// first period runs from reset
		run_phase("mid", 36, 46);
		if (!abort) begin
			// long lag pushes the integrator into the clamp
			run_phase("clamp", 55, 62);
		end
		if (!abort) begin
			// short lag walks the increment down to N_MIN
			run_phase("pull", 10, 14);
		end
		if (!abort) begin
			// at N_MIN this lag leaves the average just above the set point
			run_phase("settle", 66, 67);
			check_equal("settle locked", 1, int'(locked));
		end
		if (!abort) begin
			run_phase("jump", 20, 28);
			check_equal("jump locked", 0, int'(locked));
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
